// ==== design/fp_noncomp_pkg.sv ====
package fp_noncomp_pkg;

  // ----------------------------------------------------------
  // FP32 word layout
  // ----------------------------------------------------------
  localparam int unsigned FP_WIDTH = 32;
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;

  // Whole single-precision word, sign in the top bit
  typedef logic [FP_WIDTH-1:0] fp_word_t;

  // ----------------------------------------------------------
  // Operand info flags, bit 7 spare and held at zero
  // ----------------------------------------------------------
  typedef logic [7:0] fp_info_t;

  localparam int unsigned INFO_NORMAL     = 0;
  localparam int unsigned INFO_SUBNORMAL  = 1;
  localparam int unsigned INFO_ZERO       = 2;
  localparam int unsigned INFO_INF        = 3;
  localparam int unsigned INFO_NAN        = 4;
  localparam int unsigned INFO_SIGNALLING = 5;
  localparam int unsigned INFO_QUIET      = 6;

  // ----------------------------------------------------------
  // Operation codes and sub-operations
  // ----------------------------------------------------------
  typedef logic [1:0] fp_op_t;

  localparam fp_op_t OP_SGNJ     = 2'd0;
  localparam fp_op_t OP_MINMAX   = 2'd1;
  localparam fp_op_t OP_CMP      = 2'd2;
  localparam fp_op_t OP_CLASSIFY = 2'd3;

  typedef logic [1:0] fp_subop_t;

  // Sign injection
  localparam fp_subop_t SUB_SGNJ  = 2'd0;
  localparam fp_subop_t SUB_SGNJN = 2'd1;
  localparam fp_subop_t SUB_SGNJX = 2'd2;
  localparam fp_subop_t SUB_MOVE  = 2'd3;
  // Min/max
  localparam fp_subop_t SUB_MIN = 2'd0;
  localparam fp_subop_t SUB_MAX = 2'd1;
  // Comparisons
  localparam fp_subop_t SUB_LE = 2'd0;
  localparam fp_subop_t SUB_LT = 2'd1;
  localparam fp_subop_t SUB_EQ = 2'd2;

  // ----------------------------------------------------------
  // Status flags NV DZ OF UF NX, MSB first
  // ----------------------------------------------------------
  typedef logic [4:0] fp_status_t;

  localparam int unsigned STATUS_NV = 4;

  // ----------------------------------------------------------
  // One-hot class mask
  // ----------------------------------------------------------
  typedef logic [9:0] fp_classmask_t;

  localparam int unsigned CLASS_NEGINF     = 0;
  localparam int unsigned CLASS_NEGNORM    = 1;
  localparam int unsigned CLASS_NEGSUBNORM = 2;
  localparam int unsigned CLASS_NEGZERO    = 3;
  localparam int unsigned CLASS_POSZERO    = 4;
  localparam int unsigned CLASS_POSSUBNORM = 5;
  localparam int unsigned CLASS_POSNORM    = 6;
  localparam int unsigned CLASS_POSINF     = 7;
  localparam int unsigned CLASS_SNAN       = 8;
  localparam int unsigned CLASS_QNAN       = 9;

  // Positive quiet NaN with only the top mantissa bit set
  localparam fp_word_t CANONICAL_QNAN =
      {1'b0, {EXP_BITS{1'b1}}, 1'b1, {(MAN_BITS-1){1'b0}}};

endpackage

// ==== design/fp_operand_if.sv ====
`timescale 1ns/1ps

interface fp_operand_if import fp_noncomp_pkg::*; ();

  // Raw operand words after the input register chain
  fp_word_t  operand_a;
  fp_word_t  operand_b;
  // Classifier results, one per operand
  fp_info_t  info_a;
  fp_info_t  info_b;
  // Operation selectors shared by both units
  fp_subop_t sub_op;
  logic      op_mod;

  // Driving side, top level
  modport src (
    output operand_a, operand_b, info_a, info_b, sub_op, op_mod
  );

  // Receiving side, operation units
  modport sink (
    input operand_a, operand_b, info_a, info_b, sub_op, op_mod
  );

endinterface

// ==== design/fp_classifier.sv ====
`timescale 1ns/1ps

module fp_classifier import fp_noncomp_pkg::*; (
  input  fp_word_t operand_i,
  output fp_info_t info_o
);

  // Field split of the FP32 word
  logic [EXP_BITS-1:0] exponent;
  logic [MAN_BITS-1:0] mantissa;
  logic                exp_ones;
  logic                exp_zero;
  logic                man_zero;
  logic                is_nan;

  assign exponent = operand_i[FP_WIDTH-2:MAN_BITS];
  assign mantissa = operand_i[MAN_BITS-1:0];

  // Exponent extremes decide the special classes
  assign exp_ones = &exponent;
  assign exp_zero = ~(|exponent);
  assign man_zero = ~(|mantissa);
  // All-ones exponent with nonzero fraction
  assign is_nan   = exp_ones & ~man_zero;

  always_comb begin
    info_o                  = '0;
    info_o[INFO_NORMAL]     = ~exp_zero & ~exp_ones;
    info_o[INFO_SUBNORMAL]  = exp_zero & ~man_zero;
    info_o[INFO_ZERO]       = exp_zero & man_zero;
    info_o[INFO_INF]        = exp_ones & man_zero;
    info_o[INFO_NAN]        = is_nan;
    // Top fraction bit tells quiet from signalling
    info_o[INFO_SIGNALLING] = is_nan & ~mantissa[MAN_BITS-1];
    info_o[INFO_QUIET]      = is_nan & mantissa[MAN_BITS-1];
  end

endmodule

// ==== design/fp_pipe_regs.sv ====
`timescale 1ns/1ps

module fp_pipe_regs #(
  parameter int unsigned NumRegs = 1,
  parameter int unsigned Width   = 32
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             flush_i,
  input  logic [Width-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,
  output logic [Width-1:0] data_o,
  output logic             valid_o,
  input  logic             ready_i,
  output logic             busy_o
);

  // Index i is the value after i register stages
  logic [NumRegs:0][Width-1:0] data_q;
  logic [NumRegs:0]            valid_q;
  // Ready is purely combinational along the chain
  logic [NumRegs:0]            ready;

  // Chain entry
  assign data_q[0]  = data_i;
  assign valid_q[0] = valid_i;
  assign ready_o    = ready[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic load;

    // Advance when downstream takes data or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    // Payload moves only with a real item
    assign load     = ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (reset_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // Chain exit, ready comes from downstream
  assign ready[NumRegs] = ready_i;
  assign data_o         = data_q[NumRegs];
  assign valid_o        = valid_q[NumRegs];

  // Busy covers register stages only
  if (NumRegs == 0) begin : gen_no_busy
    assign busy_o = 1'b0;
  end else begin : gen_busy
    assign busy_o = |valid_q[NumRegs:1];
  end

endmodule

// ==== design/fp_order_ops.sv ====
`timescale 1ns/1ps

module fp_order_ops import fp_noncomp_pkg::*; (
  fp_operand_if.sink opnd,
  output fp_word_t   minmax_result_o,
  output fp_status_t minmax_status_o,
  output fp_word_t   cmp_result_o,
  output fp_status_t cmp_status_o
);

  // ----------------------------------------------------------
  // Shared ordering logic
  // ----------------------------------------------------------
  logic sign_a;
  logic sign_b;
  logic nan_a;
  logic nan_b;
  logic any_nan;
  logic any_snan;
  logic operands_equal;
  logic operand_a_smaller;

  assign sign_a   = opnd.operand_a[FP_WIDTH-1];
  assign sign_b   = opnd.operand_b[FP_WIDTH-1];
  assign nan_a    = opnd.info_a[INFO_NAN];
  assign nan_b    = opnd.info_b[INFO_NAN];
  assign any_nan  = nan_a | nan_b;
  assign any_snan = opnd.info_a[INFO_SIGNALLING] | opnd.info_b[INFO_SIGNALLING];

  // Identical words, or +0 against -0
  assign operands_equal = (opnd.operand_a == opnd.operand_b) ||
                          (opnd.info_a[INFO_ZERO] && opnd.info_b[INFO_ZERO]);
  // Sign-magnitude order, flipped once a sign is set
  assign operand_a_smaller = (opnd.operand_a < opnd.operand_b) ^ (sign_a || sign_b);

  // ----------------------------------------------------------
  // Minimum / maximum
  // ----------------------------------------------------------
  always_comb begin
    minmax_status_o            = '0;
    // Quiet operation, only signalling NaNs are invalid
    minmax_status_o[STATUS_NV] = any_snan;
    if (nan_a && nan_b) begin
      minmax_result_o = CANONICAL_QNAN;
    end else if (nan_a) begin
      minmax_result_o = opnd.operand_b;
    end else if (nan_b) begin
      minmax_result_o = opnd.operand_a;
    end else if (opnd.sub_op == SUB_MAX) begin
      minmax_result_o = operand_a_smaller ? opnd.operand_b : opnd.operand_a;
    end else begin
      // SUB_MIN
      minmax_result_o = operand_a_smaller ? opnd.operand_a : opnd.operand_b;
    end
  end

  // ----------------------------------------------------------
  // Comparisons, boolean in bit 0
  // ----------------------------------------------------------
  always_comb begin
    cmp_result_o = '0;
    cmp_status_o = '0;
    if (any_snan) begin
      // Always false and invalid
      cmp_status_o[STATUS_NV] = 1'b1;
    end else begin
      case (opnd.sub_op)
        SUB_LE: begin
          // Signalling relation, quiet NaNs are invalid too
          if (any_nan) cmp_status_o[STATUS_NV] = 1'b1;
          else cmp_result_o[0] = (operand_a_smaller | operands_equal) ^ opnd.op_mod;
        end
        SUB_LT: begin
          if (any_nan) cmp_status_o[STATUS_NV] = 1'b1;
          else cmp_result_o[0] = (operand_a_smaller & ~operands_equal) ^ opnd.op_mod;
        end
        SUB_EQ: begin
          // NaN never equal, so only the inversion shows
          if (any_nan) cmp_result_o[0] = opnd.op_mod;
          else cmp_result_o[0] = operands_equal ^ opnd.op_mod;
        end
        default: cmp_result_o = '0;
      endcase
    end
  end

endmodule

// ==== design/fp_sign_class_ops.sv ====
`timescale 1ns/1ps

module fp_sign_class_ops import fp_noncomp_pkg::*; (
  fp_operand_if.sink opnd,
  output fp_word_t      sgnj_result_o,
  output fp_classmask_t class_mask_o
);

  logic sign_a;
  logic sign_b;

  assign sign_a = opnd.operand_a[FP_WIDTH-1];
  assign sign_b = opnd.operand_b[FP_WIDTH-1];

  // ----------------------------------------------------------
  // Sign injection onto operand A
  // ----------------------------------------------------------
  always_comb begin
    sgnj_result_o = opnd.operand_a;
    case (opnd.sub_op)
      SUB_SGNJ:  sgnj_result_o[FP_WIDTH-1] = sign_b;
      SUB_SGNJN: sgnj_result_o[FP_WIDTH-1] = ~sign_b;
      SUB_SGNJX: sgnj_result_o[FP_WIDTH-1] = sign_a ^ sign_b;
      // Plain move keeps A as is
      default:   sgnj_result_o = opnd.operand_a;
    endcase
  end

  // ----------------------------------------------------------
  // Class mask of operand A
  // ----------------------------------------------------------
  always_comb begin
    class_mask_o = '0;
    if (opnd.info_a[INFO_NORMAL]) begin
      class_mask_o[sign_a ? CLASS_NEGNORM : CLASS_POSNORM] = 1'b1;
    end else if (opnd.info_a[INFO_SUBNORMAL]) begin
      class_mask_o[sign_a ? CLASS_NEGSUBNORM : CLASS_POSSUBNORM] = 1'b1;
    end else if (opnd.info_a[INFO_ZERO]) begin
      class_mask_o[sign_a ? CLASS_NEGZERO : CLASS_POSZERO] = 1'b1;
    end else if (opnd.info_a[INFO_INF]) begin
      class_mask_o[sign_a ? CLASS_NEGINF : CLASS_POSINF] = 1'b1;
    end else if (opnd.info_a[INFO_SIGNALLING]) begin
      // NaN sign is ignored
      class_mask_o[CLASS_SNAN] = 1'b1;
    end else begin
      class_mask_o[CLASS_QNAN] = 1'b1;
    end
  end

endmodule

// ==== design/fp_noncomp.sv ====
`timescale 1ns/1ps

module fp_noncomp import fp_noncomp_pkg::*; #(
  parameter int unsigned NumInpRegs = 1,
  parameter int unsigned NumOutRegs = 1,
  parameter int unsigned TagWidth   = 8
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Request side
  input  fp_word_t            operand_a_i,
  input  fp_word_t            operand_b_i,
  input  fp_op_t              op_i,
  input  fp_subop_t           sub_op_i,
  input  logic                op_mod_i,
  input  logic [TagWidth-1:0] tag_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic                flush_i,
  // Response side
  output fp_word_t            result_o,
  output fp_status_t          status_o,
  output logic                extension_bit_o,
  output fp_classmask_t       class_mask_o,
  output logic                is_class_o,
  output logic [TagWidth-1:0] tag_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic                busy_o
);

  // Flat payload widths of the two chains
  localparam int unsigned INP_WIDTH = 2 * FP_WIDTH + $bits(fp_op_t) + $bits(fp_subop_t)
                                      + 1 + TagWidth;
  localparam int unsigned OUT_WIDTH = FP_WIDTH + $bits(fp_status_t) + 1
                                      + $bits(fp_classmask_t) + 1 + TagWidth;

  // ----------------------------------------------------------
  // Input register chain
  // ----------------------------------------------------------
  logic [INP_WIDTH-1:0] inp_data;
  logic                 inp_valid;
  logic                 mid_ready;
  logic                 inp_busy;
  fp_word_t             stage_a;
  fp_word_t             stage_b;
  fp_op_t               stage_op;
  fp_subop_t            stage_sub_op;
  logic                 stage_op_mod;
  logic [TagWidth-1:0]  stage_tag;

  fp_pipe_regs #(
    .NumRegs ( NumInpRegs ),
    .Width   ( INP_WIDTH  )
  ) i_inp_pipe (
    .clk_i   ( clk_i ),
    .reset_i ( reset_i ),
    .flush_i ( flush_i ),
    .data_i  ( {operand_a_i, operand_b_i, op_i, sub_op_i, op_mod_i, tag_i} ),
    .valid_i ( in_valid_i ),
    .ready_o ( in_ready_o ),
    .data_o  ( inp_data ),
    .valid_o ( inp_valid ),
    .ready_i ( mid_ready ),
    .busy_o  ( inp_busy )
  );

  assign {stage_a, stage_b, stage_op, stage_sub_op, stage_op_mod, stage_tag} = inp_data;

  // ----------------------------------------------------------
  // Classification and operation units
  // ----------------------------------------------------------
  fp_operand_if opnd ();

  assign opnd.operand_a = stage_a;
  assign opnd.operand_b = stage_b;
  assign opnd.sub_op    = stage_sub_op;
  assign opnd.op_mod    = stage_op_mod;

  fp_classifier i_class_a (.operand_i(stage_a), .info_o(opnd.info_a));
  fp_classifier i_class_b (.operand_i(stage_b), .info_o(opnd.info_b));

  fp_word_t      sgnj_result;
  fp_classmask_t class_mask;
  fp_word_t      minmax_result;
  fp_status_t    minmax_status;
  fp_word_t      cmp_result;
  fp_status_t    cmp_status;

  fp_order_ops i_order_ops (
    .opnd            ( opnd          ),
    .minmax_result_o ( minmax_result ),
    .minmax_status_o ( minmax_status ),
    .cmp_result_o    ( cmp_result    ),
    .cmp_status_o    ( cmp_status    )
  );

  fp_sign_class_ops i_sign_class_ops (
    .opnd          ( opnd        ),
    .sgnj_result_o ( sgnj_result ),
    .class_mask_o  ( class_mask  )
  );

  // ----------------------------------------------------------
  // Result selection
  // ----------------------------------------------------------
  fp_word_t   result_d;
  fp_status_t status_d;
  logic       extension_bit_d;
  logic       is_class_d;

  always_comb begin
    // Classify values, also used as fallback
    result_d        = '0;
    status_d        = '0;
    extension_bit_d = 1'b0;
    case (stage_op)
      OP_SGNJ: begin
        result_d = sgnj_result;
        // Sign-extend into an integer register when op_mod is set
        extension_bit_d = stage_op_mod ? sgnj_result[FP_WIDTH-1] : 1'b1;
      end
      OP_MINMAX: begin
        result_d        = minmax_result;
        status_d        = minmax_status;
        extension_bit_d = 1'b1;
      end
      OP_CMP: begin
        result_d = cmp_result;
        status_d = cmp_status;
      end
      default: result_d = '0;
    endcase
  end

  assign is_class_d = (stage_op == OP_CLASSIFY);

  // ----------------------------------------------------------
  // Output register chain
  // ----------------------------------------------------------
  logic [OUT_WIDTH-1:0] out_data;
  logic                 out_busy;

  fp_pipe_regs #(
    .NumRegs ( NumOutRegs ),
    .Width   ( OUT_WIDTH  )
  ) i_out_pipe (
    .clk_i   ( clk_i ),
    .reset_i ( reset_i ),
    .flush_i ( flush_i ),
    .data_i  ( {result_d, status_d, extension_bit_d, class_mask, is_class_d, stage_tag} ),
    .valid_i ( inp_valid ),
    .ready_o ( mid_ready ),
    .data_o  ( out_data ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i ),
    .busy_o  ( out_busy )
  );

  assign {result_o, status_o, extension_bit_o, class_mask_o, is_class_o, tag_o} = out_data;

  // Any valid register in either chain
  assign busy_o = inp_busy | out_busy;

endmodule

// ==== tb/fp_ref_model.svh ====
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Expected response fields of one item, tag kept by the testbench
typedef struct packed {
  fp_word_t      result;
  fp_status_t    status;
  logic          ext_bit;
  fp_classmask_t class_mask;
  logic          is_class;
} ref_out_t;

// ------------------------------------------------------------
// Raw field tests on an FP32 word
// ------------------------------------------------------------
function automatic logic ref_is_nan(fp_word_t w);
  return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
endfunction

function automatic logic ref_is_snan(fp_word_t w);
  return ref_is_nan(w) && !w[22];
endfunction

function automatic logic ref_is_zero(fp_word_t w);
  return w[30:0] == 31'd0;
endfunction

// Unsigned key that grows with the real value, -0 just below +0
function automatic logic [31:0] order_key(fp_word_t w);
  return w[31] ? ~w : (w | 32'h8000_0000);
endfunction

// ------------------------------------------------------------
// Per-operation rules
// ------------------------------------------------------------
function automatic fp_classmask_t ref_class_mask(fp_word_t w);
  fp_classmask_t mask;
  int unsigned   pos;
  if (ref_is_nan(w)) pos = w[22] ? CLASS_QNAN : CLASS_SNAN;
  else if (w[30:23] == 8'hff) pos = w[31] ? CLASS_NEGINF : CLASS_POSINF;
  else if (ref_is_zero(w)) pos = w[31] ? CLASS_NEGZERO : CLASS_POSZERO;
  else if (w[30:23] == 8'h00) pos = w[31] ? CLASS_NEGSUBNORM : CLASS_POSSUBNORM;
  else pos = w[31] ? CLASS_NEGNORM : CLASS_POSNORM;
  mask      = '0;
  mask[pos] = 1'b1;
  return mask;
endfunction

function automatic fp_word_t ref_sign_inject(fp_word_t a, fp_word_t b, fp_subop_t sub);
  case (sub)
    SUB_SGNJ:  return {b[31], a[30:0]};
    SUB_SGNJN: return {~b[31], a[30:0]};
    SUB_SGNJX: return {a[31] ^ b[31], a[30:0]};
    default:   return a;
  endcase
endfunction

function automatic fp_word_t ref_min_max(fp_word_t a, fp_word_t b, fp_subop_t sub);
  logic a_lower;
  if (ref_is_nan(a) && ref_is_nan(b)) return CANONICAL_QNAN;
  if (ref_is_nan(a)) return b;
  if (ref_is_nan(b)) return a;
  a_lower = order_key(a) < order_key(b);
  if (sub == SUB_MAX) return a_lower ? b : a;
  return a_lower ? a : b;
endfunction

function automatic logic ref_compare(fp_word_t a, fp_word_t b, fp_subop_t sub, logic mod);
  logic equal;
  logic less;
  // Signed zeros compare equal
  equal = (a == b) || (ref_is_zero(a) && ref_is_zero(b));
  less  = (order_key(a) < order_key(b)) && !equal;
  if (ref_is_snan(a) || ref_is_snan(b)) return 1'b0;
  if (ref_is_nan(a) || ref_is_nan(b)) return (sub == SUB_EQ) ? mod : 1'b0;
  case (sub)
    SUB_LE:  return (less || equal) ^ mod;
    SUB_LT:  return less ^ mod;
    default: return equal ^ mod;
  endcase
endfunction

// Full expected response for one request
function automatic ref_out_t ref_expected(fp_word_t a, fp_word_t b, fp_op_t op,
                                          fp_subop_t sub, logic mod);
  ref_out_t r;
  logic     any_snan;
  logic     any_nan;
  any_snan     = ref_is_snan(a) || ref_is_snan(b);
  any_nan      = ref_is_nan(a) || ref_is_nan(b);
  r            = '0;
  r.class_mask = ref_class_mask(a);
  case (op)
    OP_SGNJ: begin
      r.result  = ref_sign_inject(a, b, sub);
      r.ext_bit = mod ? r.result[31] : 1'b1;
    end
    OP_MINMAX: begin
      r.result            = ref_min_max(a, b, sub);
      r.status[STATUS_NV] = any_snan;
      r.ext_bit           = 1'b1;
    end
    OP_CMP: begin
      r.result[0]         = ref_compare(a, b, sub, mod);
      r.status[STATUS_NV] = any_snan || (any_nan && sub != SUB_EQ);
    end
    default: r.is_class = 1'b1;
  endcase
  return r;
endfunction

`endif

// ==== tb/tb_fp_noncomp.sv ====
`timescale 1ns/1ps

module tb_fp_noncomp import fp_noncomp_pkg::*; ();

  localparam int TAG_WIDTH    = 8;
  localparam int LATENCY      = 2;
  localparam int RESET_CYCLES = 10;
  localparam int N_RAND       = 100;
  localparam int NUM_SPECIALS = 10;
  localparam int PAIRS        = NUM_SPECIALS * NUM_SPECIALS;
  localparam int FLUSH_FILL   = 1;
  localparam int TOTAL_ITEMS  = 9 * N_RAND + 8 * PAIRS + NUM_SPECIALS + FLUSH_FILL;

  // Ways of driving out_ready_i
  localparam int READY_HIGH   = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW    = 2;

  `include "fp_ref_model.svh"

  typedef struct packed {
    ref_out_t             ref_out;
    logic [TAG_WIDTH-1:0] tag;
    logic [31:0]          cycle;
    logic                 timed;
  } pending_t;

  logic                 clk_i;
  logic                 reset_i;
  fp_word_t             operand_a_i;
  fp_word_t             operand_b_i;
  fp_op_t               op_i;
  fp_subop_t            sub_op_i;
  logic                 op_mod_i;
  logic [TAG_WIDTH-1:0] tag_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  logic                 flush_i;
  fp_word_t             result_o;
  fp_status_t           status_o;
  logic                 extension_bit_o;
  fp_classmask_t        class_mask_o;
  logic                 is_class_o;
  logic [TAG_WIDTH-1:0] tag_o;
  logic                 out_valid_o;
  logic                 out_ready_i;
  logic                 busy_o;

  // Scoreboard state
  pending_t             pend_q [$];
  int                   errors = 0;
  int                   checks = 0;
  int                   accepted = 0;
  int unsigned          cycle_cnt = 0;
  int                   ready_mode = READY_HIGH;
  logic [TAG_WIDTH-1:0] next_tag;
  logic                 hold_prev = 1'b0;
  logic [56:0]          prev_snapshot;
  logic [56:0]          out_snapshot;

  fp_noncomp DUT (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .operand_a_i     ( operand_a_i     ),
    .operand_b_i     ( operand_b_i     ),
    .op_i            ( op_i            ),
    .sub_op_i        ( sub_op_i        ),
    .op_mod_i        ( op_mod_i        ),
    .tag_i           ( tag_i           ),
    .in_valid_i      ( in_valid_i      ),
    .in_ready_o      ( in_ready_o      ),
    .flush_i         ( flush_i         ),
    .result_o        ( result_o        ),
    .status_o        ( status_o        ),
    .extension_bit_o ( extension_bit_o ),
    .class_mask_o    ( class_mask_o    ),
    .is_class_o      ( is_class_o      ),
    .tag_o           ( tag_o           ),
    .out_valid_o     ( out_valid_o     ),
    .out_ready_i     ( out_ready_i     ),
    .busy_o          ( busy_o          )
  );

  assign out_snapshot = {result_o, status_o, extension_bit_o, class_mask_o, is_class_o, tag_o};

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  function automatic fp_word_t special_value(int idx);
    case (idx)
      0:       return 32'h0000_0000;  // +0
      1:       return 32'h8000_0000;  // -0
      2:       return 32'h7f80_0000;  // +inf
      3:       return 32'hff80_0000;  // -inf
      4:       return 32'h0000_0001;  // smallest subnormal
      5:       return 32'h807f_ffff;
      6:       return 32'h7fc0_0000;  // quiet NaN
      7:       return 32'h7f80_0001;  // signalling NaN
      8:       return 32'h3f80_0000;
      default: return 32'hc020_0000;
    endcase
  endfunction

  // One in four operands is a special value
  function automatic fp_word_t random_operand();
    if ($urandom_range(3, 0) == 0) return special_value($urandom_range(NUM_SPECIALS - 1, 0));
    return $urandom;
  endfunction

  // Only sub-operations that the op defines
  function automatic fp_subop_t random_sub(fp_op_t op);
    case (op)
      OP_MINMAX: return fp_subop_t'($urandom_range(1, 0));
      OP_CMP:    return fp_subop_t'($urandom_range(2, 0));
      default:   return fp_subop_t'($urandom_range(3, 0));
    endcase
  endfunction

  task automatic set_ready_mode(int mode);
    ready_mode = mode;
    if (mode != READY_RANDOM) out_ready_i = (mode == READY_HIGH);
  endtask

  always @(negedge clk_i) begin
    if (ready_mode == READY_RANDOM) out_ready_i = $urandom_range(1, 0);
  end

  // Runs from one falling edge to the falling edge after acceptance
  task automatic drive_item(fp_word_t a, fp_word_t b, fp_op_t op, fp_subop_t sub, logic mod);
    int start;
    operand_a_i = a;
    operand_b_i = b;
    op_i        = op;
    sub_op_i    = sub;
    op_mod_i    = mod;
    tag_i       = next_tag;
    in_valid_i  = 1'b1;
    start       = accepted;
    do @(negedge clk_i); while (accepted == start);
    next_tag++;
  endtask

  // Negative op_sel picks a random op per item
  task automatic run_random(int count, int op_sel);
    fp_op_t op;
    for (int i = 0; i < count; i++) begin
      op = (op_sel < 0) ? fp_op_t'($urandom_range(3, 0)) : fp_op_t'(op_sel);
      drive_item(random_operand(), random_operand(), op, random_sub(op), $urandom_range(1, 0));
    end
  endtask

  task automatic finish_test(string name);
    in_valid_i = 1'b0;
    while (pend_q.size() != 0 || busy_o) @(negedge clk_i);
    $display("Test %s finished, %0d items checked, %0d errors so far", name, checks, errors);
  endtask

  // ------------------------------------------------------------
  // Scoreboard
  // ------------------------------------------------------------
  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
    errors++;
    $display("FAIL %s got %h expected %h", name, got, want);
  endtask

  task automatic check_output();
    pending_t want;
    if (pend_q.size() == 0) begin
      errors++;
      $display("Output with tag %h arrived while no item was expected", tag_o);
    end else begin
      want = pend_q.pop_front();
      checks++;
      assert (result_o == want.ref_out.result)
        else report_mismatch("result_o", result_o, want.ref_out.result);
      assert (status_o == want.ref_out.status)
        else report_mismatch("status_o", status_o, want.ref_out.status);
      assert (extension_bit_o == want.ref_out.ext_bit)
        else report_mismatch("extension_bit_o", extension_bit_o, want.ref_out.ext_bit);
      assert (class_mask_o == want.ref_out.class_mask)
        else report_mismatch("class_mask_o", class_mask_o, want.ref_out.class_mask);
      assert (is_class_o == want.ref_out.is_class)
        else report_mismatch("is_class_o", is_class_o, want.ref_out.is_class);
      assert (tag_o == want.tag) else report_mismatch("tag_o", tag_o, want.tag);
      // Latency only counts when the sink never stalled
      if (want.timed) begin
        assert (int'(cycle_cnt - want.cycle) == LATENCY) else begin
          errors++;
          $display("Item with tag %h took %0d cycles instead of %0d",
                   want.tag, int'(cycle_cnt - want.cycle), LATENCY);
        end
      end
    end
  endtask

  always @(posedge clk_i) begin : scoreboard
    pending_t item;
    cycle_cnt++;
    if (reset_i) begin
      hold_prev = 1'b0;
    end else begin
      // Stalled outputs stay frozen
      if (hold_prev) begin
        assert (out_valid_o && out_snapshot == prev_snapshot) else begin
          errors++;
          $display("FAIL outputs under back-pressure was %h now %h, out_valid_o %h",
                   prev_snapshot, out_snapshot, out_valid_o);
        end
      end
      hold_prev     = out_valid_o && !out_ready_i && !flush_i;
      prev_snapshot = out_snapshot;
      if (flush_i) begin
        pend_q.delete();
      end else begin
        if (out_valid_o && out_ready_i) check_output();
        if (in_valid_i && in_ready_o) begin
          item.ref_out = ref_expected(operand_a_i, operand_b_i, op_i, sub_op_i, op_mod_i);
          item.tag     = tag_i;
          item.cycle   = cycle_cnt;
          item.timed   = (ready_mode == READY_HIGH);
          pend_q.push_back(item);
          accepted++;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin : stimulus
    void'($urandom(32'h7d00));
    reset_i     = 1'b1;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = OP_SGNJ;
    sub_op_i    = SUB_SGNJ;
    op_mod_i    = 1'b0;
    tag_i       = '0;
    out_ready_i = 1'b1;
    next_tag    = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    run_random(2 * N_RAND, OP_SGNJ);
    finish_test("sign injection");

    for (int i = 0; i < NUM_SPECIALS; i++)
      for (int j = 0; j < NUM_SPECIALS; j++)
        for (int s = 0; s < 2; s++)
          drive_item(special_value(i), special_value(j), OP_MINMAX, fp_subop_t'(s), 1'b0);
    run_random(N_RAND, OP_MINMAX);
    finish_test("min/max");

    for (int i = 0; i < NUM_SPECIALS; i++)
      for (int j = 0; j < NUM_SPECIALS; j++)
        for (int s = 0; s < 3; s++)
          for (int m = 0; m < 2; m++)
            drive_item(special_value(i), special_value(j), OP_CMP, fp_subop_t'(s), 1'(m));
    run_random(N_RAND, OP_CMP);
    finish_test("comparison");

    for (int i = 0; i < NUM_SPECIALS; i++)
      drive_item(special_value(i), random_operand(), OP_CLASSIFY, random_sub(OP_CLASSIFY), 1'b0);
    run_random(N_RAND, OP_CLASSIFY);
    finish_test("classification");

    set_ready_mode(READY_RANDOM);
    run_random(3 * N_RAND, -1);
    finish_test("back-pressure");
    set_ready_mode(READY_HIGH);

    // Item in the input stage and a new one taken on the flush edge are both dropped
    set_ready_mode(READY_LOW);
    run_random(FLUSH_FILL, -1);
    operand_a_i = random_operand();
    tag_i       = next_tag;
    in_valid_i  = 1'b1;
    flush_i     = 1'b1;
    @(negedge clk_i);
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    next_tag++;
    assert (busy_o == 1'b0) else report_mismatch("busy_o", busy_o, 0);
    assert (out_valid_o == 1'b0) else report_mismatch("out_valid_o", out_valid_o, 0);
    set_ready_mode(READY_HIGH);
    run_random(N_RAND, -1);
    finish_test("flush");

    $display("Checked %0d items with %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Generous bound of 20 cycles per item
  initial begin : watchdog
    repeat (RESET_CYCLES + TOTAL_ITEMS * 20) @(posedge clk_i);
    $display("Watchdog expired, the tests did not complete in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+tb
design/fp_noncomp_pkg.sv
design/fp_operand_if.sv
design/fp_classifier.sv
design/fp_pipe_regs.sv
design/fp_order_ops.sv
design/fp_sign_class_ops.sv
design/fp_noncomp.sv
tb/tb_fp_noncomp.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_fp_noncomp \
  -f sources.f -o sim_fp_noncomp &&
./obj_dir/sim_fp_noncomp | tee sim.log &&
grep -qx "ALL TESTS PASSED" sim.log &&
echo "Simulation passed" && exit 0 ||
{ echo "Simulation failed, see sim.log"; exit 1; }
